// ==== source/gf_config.svh ====
// GF(2^8) field configuration
`ifndef GF_CONFIG_SVH
`define GF_CONFIG_SVH

// ============================================================================
// Field size and reduction polynomial
// ============================================================================

// Width of one field element in bits
`define GF_M 8

// Low GF_M bits of x^8+x^4+x^3+x^2+1
// The leading x^8 term is implied by the shift out of the top bit
`define GF_POLY 8'h1D

// ============================================================================
// Divider timing
// ============================================================================

// Accumulate steps that follow a divider load, so that the accumulator
// reaches b^(2^M-2) which is the inverse of b
`define GF_DIV_STEPS (`GF_M - 1)

`endif

// ==== source/gf_pkg.sv ====
// GF(2^8) shared types
`include "gf_config.svh"

package gf_pkg;

	// ========================================================================
	// Field element
	// ========================================================================

	// One element in the standard basis, bit i is the coefficient of alpha^i
	typedef logic [`GF_M-1:0] gf_elem_t;

	// ========================================================================
	// Operation codes
	// ========================================================================

	// Code 3 is unused and is handled as a multiply by the control block
	typedef enum logic [1:0] {
		// Product a*b
		OP_MUL  = 2'd0,
		// Cube of a, b is ignored
		OP_CUBE = 2'd1,
		// Quotient a/b, gives 0 when b is 0
		OP_DIV  = 2'd2
	} gf_op_t;

endpackage

// ==== source/gf_parallel_multiplier.sv ====
// Bit-parallel standard basis multiplier
`timescale 1ns/1ps
`include "gf_config.svh"

module gf_parallel_multiplier (
	input  gf_pkg::gf_elem_t a,
	input  gf_pkg::gf_elem_t b,
	output gf_pkg::gf_elem_t product
);

	// ========================================================================
	// Successive alpha multiples of a
	// ========================================================================

	// Entry i holds a*alpha^i, already reduced into the field
	gf_pkg::gf_elem_t multiple [`GF_M];

	// Multiply by alpha is a left shift, and the bit shifted out of the top
	// folds back in through the low bits of the polynomial
	function automatic gf_pkg::gf_elem_t mul_alpha(input gf_pkg::gf_elem_t v);
		mul_alpha = {v[`GF_M-2:0], 1'b0} ^ ({`GF_M{v[`GF_M-1]}} & `GF_POLY);
	endfunction

	always_comb begin
		multiple[0] = a;
		for (int i = 1; i < `GF_M; i++) begin
			multiple[i] = mul_alpha(multiple[i-1]);
		end
	end

	// ========================================================================
	// Selection by the bits of b
	// ========================================================================

	// Each set bit of b adds in the matching multiple of a
	// This is the transposed matrix-vector product of the PPBML
	always_comb begin
		product = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (b[i]) begin
				product = product ^ multiple[i];
			end
		end
	end

	// Squaring through this block (a equal to b) keeps a nonzero value nonzero
	// since the Frobenius map is a bijection on the field
	// The divider relies on that when it checks its square register

endmodule

// ==== source/gf_cube.sv ====
// GF(2^8) cube circuit
`timescale 1ns/1ps
`include "gf_config.svh"

module gf_cube (
	input  gf_pkg::gf_elem_t a,
	output gf_pkg::gf_elem_t cube
);

	// ========================================================================
	// Alpha power tables, built at elaboration
	// ========================================================================

	// One step of multiplication by alpha with reduction
	function automatic gf_pkg::gf_elem_t mul_alpha(input gf_pkg::gf_elem_t v);
		mul_alpha = {v[`GF_M-2:0], 1'b0} ^ ({`GF_M{v[`GF_M-1]}} & `GF_POLY);
	endfunction

	// alpha^n by repeated multiplication, only run on constants
	function automatic gf_pkg::gf_elem_t alpha_pow(input int n);
		gf_pkg::gf_elem_t v;
		v = 1;
		for (int k = 0; k < n; k++) begin
			v = mul_alpha(v);
		end
		return v;
	endfunction

	// Linear terms, entry i is alpha^(3i)
	function automatic logic [`GF_M*`GF_M-1:0] linear_table();
		logic [`GF_M*`GF_M-1:0] t;
		t = '0;
		for (int i = 0; i < `GF_M; i++) begin
			t[i*`GF_M +: `GF_M] = alpha_pow(3 * i);
		end
		return t;
	endfunction

	// Cross terms, entry i*M+j is alpha^(2i+j)+alpha^(2j+i) for i<j
	// Entries on or below the diagonal stay zero and are never read
	function automatic logic [`GF_M*`GF_M*`GF_M-1:0] cross_table();
		logic [`GF_M*`GF_M*`GF_M-1:0] t;
		t = '0;
		for (int i = 0; i < `GF_M; i++) begin
			for (int j = i + 1; j < `GF_M; j++) begin
				t[(i*`GF_M+j)*`GF_M +: `GF_M] = alpha_pow(2*i + j) ^ alpha_pow(2*j + i);
			end
		end
		return t;
	endfunction

	localparam logic [`GF_M*`GF_M-1:0]       LINEAR_TERMS = linear_table();
	localparam logic [`GF_M*`GF_M*`GF_M-1:0] CROSS_TERMS  = cross_table();

	// ========================================================================
	// Cube as a sum of linear and cross terms
	// ========================================================================

	// (sum a_i x^i)^3 = sum a_i x^(3i) + sum over i<j of a_i a_j
	// weighted by (x^(2i+j) + x^(2j+i)), squares of bits being the bits
	// Far fewer gates than a squarer feeding a full multiplier
	always_comb begin
		cube = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (a[i]) begin
				cube = cube ^ LINEAR_TERMS[i*`GF_M +: `GF_M];
			end
		end
		for (int i = 0; i < `GF_M; i++) begin
			for (int j = i + 1; j < `GF_M; j++) begin
				if (a[i] && a[j]) begin
					cube = cube ^ CROSS_TERMS[(i*`GF_M+j)*`GF_M +: `GF_M];
				end
			end
		end
	end

endmodule

// ==== source/gf_fermat_divider.sv ====
// Fermat inverter and divider
`timescale 1ns/1ps

module gf_fermat_divider (
	input  logic             clk,
	input  logic             reset,
	input  logic             load,
	input  gf_pkg::gf_elem_t denominator,
	input  gf_pkg::gf_elem_t numerator,
	output gf_pkg::gf_elem_t quotient
);

	// Inverse by Fermat, b^-1 = b^(2^M-2) = b^2 * b^4 * ... * b^(2^(M-1))
	// The square register walks through b^2, b^4, ... and the accumulator
	// collects their product, one factor per clock

	// ========================================================================
	// Datapath
	// ========================================================================

	// Holds b^(2^(k+1)) after step k
	gf_pkg::gf_elem_t square_reg;
	// Holds b^(2^(k+1)-2) after step k
	gf_pkg::gf_elem_t acc_reg;

	gf_pkg::gf_elem_t square_src;
	gf_pkg::gf_elem_t square_next;
	gf_pkg::gf_elem_t acc_next;

	// On a load the fresh denominator is squared instead of the register
	assign square_src = load ? denominator : square_reg;

	// Squarer
	gf_parallel_multiplier i_squarer (
		.a       (square_src),
		.b       (square_src),
		.product (square_next)
	);

	// Accumulator step, multiplies in the current power of b
	gf_parallel_multiplier i_accumulator (
		.a       (acc_reg),
		.b       (square_reg),
		.product (acc_next)
	);

	// Numerator times the running inverse, valid once the steps are done
	gf_parallel_multiplier i_numerator (
		.a       (numerator),
		.b       (acc_reg),
		.product (quotient)
	);

	// ========================================================================
	// Registers
	// ========================================================================

	// The loop steps on every clock after a load and the caller counts the
	// GF_DIV_STEPS steps, after which acc_reg holds the inverse
	// A zero denominator zeroes the square register, so the accumulator and
	// the quotient fall to zero as well
	always_ff @(posedge clk) begin
		if (reset) begin
			square_reg <= '0;
			acc_reg    <= '0;
		end else begin
			square_reg <= square_next;
			acc_reg    <= load ? gf_pkg::gf_elem_t'(1) : acc_next;
		end
	end

	// A nonzero denominator must leave a nonzero square after the load,
	// otherwise the whole inverse chain collapses to zero
	a_square_nonzero : assert property (@(posedge clk) disable iff (reset)
		load && (denominator != '0) |=> square_reg != '0);

endmodule

// ==== source/gf_op_control.sv ====
// GF operation register block
`timescale 1ns/1ps
`include "gf_config.svh"

module gf_op_control (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  gf_pkg::gf_op_t   op,
	input  gf_pkg::gf_elem_t operand_a,
	input  gf_pkg::gf_elem_t operand_b,
	input  gf_pkg::gf_elem_t product,
	input  gf_pkg::gf_elem_t cube,
	input  gf_pkg::gf_elem_t quotient,
	output gf_pkg::gf_elem_t a_reg,
	output gf_pkg::gf_elem_t b_reg,
	output gf_pkg::gf_elem_t result,
	output logic             div_load,
	output logic             busy,
	output logic             done
);

	// Wide enough to hold GF_DIV_STEPS
	localparam int STEP_W = $clog2(`GF_DIV_STEPS + 1);

	// ========================================================================
	// Command acceptance
	// ========================================================================

	gf_pkg::gf_op_t      op_reg;
	gf_pkg::gf_op_t      op_accepted;
	logic [STEP_W-1:0]   step_count;
	logic                accept;
	logic                finish;
	gf_pkg::gf_elem_t    selected;

	// A start is only taken while idle, a start during busy is dropped
	assign accept = start && !busy;

	// The unused code 3 runs as a multiply
	assign op_accepted = ((op == gf_pkg::OP_CUBE) || (op == gf_pkg::OP_DIV)) ?
		op : gf_pkg::OP_MUL;

	// The divider loads on the accepting edge, straight from operand_b
	assign div_load = accept && (op == gf_pkg::OP_DIV);

	// ========================================================================
	// Completion and result selection
	// ========================================================================

	// Multiply and cube are combinational and finish one edge after
	// acceptance, a divide waits until the divider has stepped GF_DIV_STEPS
	// times so that the result lands GF_M edges after acceptance
	assign finish = busy && ((op_reg != gf_pkg::OP_DIV) ||
		(step_count == STEP_W'(`GF_DIV_STEPS)));

	always_comb begin
		case (op_reg)
			gf_pkg::OP_CUBE: selected = cube;
			gf_pkg::OP_DIV:  selected = quotient;
			default:         selected = product;
		endcase
	end

	// ========================================================================
	// Control and operand registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			done       <= 1'b0;
			op_reg     <= gf_pkg::OP_MUL;
			step_count <= '0;
			a_reg      <= '0;
			b_reg      <= '0;
			result     <= '0;
		end else begin
			// Done is a single pulse on the edge that ends the operation
			done <= finish;

			if (accept) begin
				busy       <= 1'b1;
				op_reg     <= op_accepted;
				step_count <= '0;
				a_reg      <= operand_a;
				b_reg      <= operand_b;
			end else if (finish) begin
				busy   <= 1'b0;
				result <= selected;
			end else if (busy) begin
				// Only a divide stays busy long enough to get here
				step_count <= step_count + 1'b1;
			end
		end
	end

	// Every operation takes at least one edge and a new start is only seen
	// once busy has dropped, so two done pulses can never touch
	a_done_single : assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

	// A divide must end exactly GF_DIV_STEPS + 1 edges after the divider load
	// that started it, otherwise the result is taken from a partly stepped
	// accumulator
	a_load_aligned : assert property (@(posedge clk) disable iff (reset)
		finish && (op_reg == gf_pkg::OP_DIV) |-> $past(div_load, `GF_DIV_STEPS + 1));

endmodule

// ==== source/gf_alu_top.sv ====
// GF(2^8) arithmetic unit
`timescale 1ns/1ps

module gf_alu_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  gf_pkg::gf_op_t   op,
	input  gf_pkg::gf_elem_t operand_a,
	input  gf_pkg::gf_elem_t operand_b,
	output gf_pkg::gf_elem_t result,
	output logic             done,
	output logic             busy
);

	// Latched operands from the control block
	gf_pkg::gf_elem_t a_reg;
	gf_pkg::gf_elem_t b_reg;

	// Results of the three arithmetic units
	gf_pkg::gf_elem_t product;
	gf_pkg::gf_elem_t cube;
	gf_pkg::gf_elem_t quotient;

	logic div_load;

	// ========================================================================
	// Command register and result select
	// ========================================================================

	gf_op_control i_control (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.product   (product),
		.cube      (cube),
		.quotient  (quotient),
		.a_reg     (a_reg),
		.b_reg     (b_reg),
		.result    (result),
		.div_load  (div_load),
		.busy      (busy),
		.done      (done)
	);

	// ========================================================================
	// Arithmetic units
	// ========================================================================

	gf_parallel_multiplier i_multiplier (
		.a       (a_reg),
		.b       (b_reg),
		.product (product)
	);

	gf_cube i_cube (
		.a    (a_reg),
		.cube (cube)
	);

	// Denominator comes from the raw operand since the load happens on the
	// same edge that latches b_reg
	gf_fermat_divider i_divider (
		.clk         (clk),
		.reset       (reset),
		.load        (div_load),
		.denominator (operand_b),
		.numerator   (a_reg),
		.quotient    (quotient)
	);

endmodule

// ==== verification/gf_alu_ref.svh ====
// GF(2^8) reference model
`ifndef GF_ALU_REF_SVH
`define GF_ALU_REF_SVH

`include "gf_config.svh"

// Product by Horner's rule over the bits of y, high bit first
// The running sum is multiplied by x and reduced before each new bit
function automatic gf_pkg::gf_elem_t ref_mul(
	input gf_pkg::gf_elem_t x,
	input gf_pkg::gf_elem_t y
);
	gf_pkg::gf_elem_t acc;
	acc = '0;
	for (int i = `GF_M - 1; i >= 0; i--) begin
		if (acc[`GF_M-1]) begin
			acc = (acc << 1) ^ `GF_POLY;
		end else begin
			acc = acc << 1;
		end
		if (y[i]) begin
			acc = acc ^ x;
		end
	end
	return acc;
endfunction

// Cube as two plain products
function automatic gf_pkg::gf_elem_t ref_cube(input gf_pkg::gf_elem_t x);
	return ref_mul(ref_mul(x, x), x);
endfunction

// Quotient x*y^254, since y^255 is 1 for every nonzero y
// A zero denominator gives zero by definition of the unit
function automatic gf_pkg::gf_elem_t ref_div(
	input gf_pkg::gf_elem_t x,
	input gf_pkg::gf_elem_t y
);
	gf_pkg::gf_elem_t inv;
	if (y == '0) begin
		return '0;
	end
	inv = gf_pkg::gf_elem_t'(1);
	// The power y^254 built from 254 single multiplies by y
	for (int k = 0; k < (1 << `GF_M) - 2; k++) begin
		inv = ref_mul(inv, y);
	end
	return ref_mul(x, inv);
endfunction

`endif

// ==== verification/gf_alu_tb.sv ====
// GF ALU testbench
`timescale 1ns/1ps
`include "gf_config.svh"

module gf_alu_tb;

	`include "gf_alu_ref.svh"

	localparam int unsigned SEED = 32'h70a22229;
	localparam int MUL_COUNT = 200;
	localparam int DIV_COUNT = 200;
	localparam int MIXED_COUNT = 60;
	// About 980 commands at worst GF_M+4 cycles each, with room to spare
	localparam int TIMEOUT_CYCLES = 20000;

	logic             clk;
	logic             reset;
	logic             start;
	gf_pkg::gf_op_t   op;
	gf_pkg::gf_elem_t operand_a;
	gf_pkg::gf_elem_t operand_b;
	gf_pkg::gf_elem_t result;
	logic             done;
	logic             busy;

	int cycle_count = 0;
	int error_count = 0;
	int test_count = 0;
	int accept_count = 0;
	int done_count = 0;

	// What the monitor expects from the command in flight
	logic             in_flight = 1'b0;
	int               accept_edge;
	int               expected_latency;
	gf_pkg::gf_elem_t expected_result;

	gf_alu_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.result    (result),
		.done      (done),
		.busy      (busy)
	);

	// ========================================================================
	// Clock, cycle counter and timeout
	// ========================================================================

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ========================================================================
	// Checking helpers
	// ========================================================================

	task automatic check_value(input int got, input int expected, input string msg);
		if (got != expected) begin
			$display("error at %0t: %s, got %0h, expected %0h", $time, msg, got, expected);
			error_count++;
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step_clock();
		@(posedge clk);
		#1;
	endtask

	// Pulse start for one edge, then scramble the inputs so that the DUT has
	// to work from its latched copies, wait for done and idle for gap cycles
	task automatic run_command(input gf_pkg::gf_op_t cmd, input gf_pkg::gf_elem_t a,
			input gf_pkg::gf_elem_t b, input int gap);
		start = 1'b1;
		op = cmd;
		operand_a = a;
		operand_b = b;
		step_clock();
		start = 1'b0;
		op = gf_pkg::OP_MUL;
		operand_a = gf_pkg::gf_elem_t'($urandom);
		operand_b = gf_pkg::gf_elem_t'($urandom);
		while (!done) begin
			step_clock();
		end
		repeat (gap) begin
			step_clock();
		end
	endtask

	task automatic report_test(input string name, input int commands, input int errors_before);
		// The monitor retires the last done on the falling edge
		@(negedge clk);
		#1;
		test_count++;
		$display("Test %0d %s finished: %0d commands, %0d errors", test_count, name,
			commands, error_count - errors_before);
		step_clock();
	endtask

	// ========================================================================
	// Monitor
	// ========================================================================

	// Samples on the falling edge where every DUT output and input is stable
	// An accepted start computes the expected result and latency up front
	always @(negedge clk) begin
		if (!reset) begin
			if (done) begin
				done_count++;
				if (!in_flight) begin
					$display("Done pulse at %0t arrived with no command in flight", $time);
					error_count++;
				end else begin
					check_value(int'(result), int'(expected_result), "result");
					check_value(cycle_count - accept_edge, expected_latency,
						"edges from acceptance to done");
					check_value(int'(busy), 0, "busy at done");
				end
				in_flight = 1'b0;
			end else if (in_flight) begin
				check_value(int'(busy), 1, "busy while in flight");
			end
			// A start seen with busy low is taken on the coming edge
			if (start && !busy) begin
				accept_count++;
				in_flight = 1'b1;
				accept_edge = cycle_count + 1;
				case (op)
					gf_pkg::OP_CUBE: expected_result = ref_cube(operand_a);
					gf_pkg::OP_DIV:  expected_result = ref_div(operand_a, operand_b);
					default:         expected_result = ref_mul(operand_a, operand_b);
				endcase
				expected_latency = (op == gf_pkg::OP_DIV) ? `GF_M : 1;
			end
		end
	end

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		int               errors_before;
		int               accepts_before;
		int               dones_before;
		gf_pkg::gf_elem_t a;
		gf_pkg::gf_elem_t b;
		void'($urandom(SEED));
		reset = 1'b1;
		start = 1'b0;
		op = gf_pkg::OP_MUL;
		operand_a = '0;
		operand_b = '0;
		repeat (5) begin
			@(posedge clk);
		end
		#1;
		reset = 1'b0;

		// Reset state, then random products with zero and one mixed in
		errors_before = error_count;
		check_value(int'(busy), 0, "busy after reset");
		check_value(int'(done), 0, "done after reset");
		check_value(int'(result), 0, "result after reset");
		for (int i = 0; i < MUL_COUNT; i++) begin
			a = gf_pkg::gf_elem_t'($urandom);
			b = gf_pkg::gf_elem_t'($urandom);
			if (i < 4) begin
				a = gf_pkg::gf_elem_t'(i % 2);
				b = gf_pkg::gf_elem_t'(i / 2);
			end else if (i < 12) begin
				a = gf_pkg::gf_elem_t'(i % 2);
			end else if (i < 20) begin
				b = gf_pkg::gf_elem_t'(i % 2);
			end
			run_command(gf_pkg::OP_MUL, a, b, int'($urandom_range(3, 0)));
		end
		report_test("multiply", MUL_COUNT, errors_before);

		// Every cube input, operand_b carries noise
		errors_before = error_count;
		for (int i = 0; i < (1 << `GF_M); i++) begin
			run_command(gf_pkg::OP_CUBE, gf_pkg::gf_elem_t'(i), gf_pkg::gf_elem_t'($urandom),
				int'($urandom_range(3, 0)));
		end
		report_test("cube", 1 << `GF_M, errors_before);

		// Random divides with a nonzero denominator
		errors_before = error_count;
		for (int i = 0; i < DIV_COUNT; i++) begin
			a = gf_pkg::gf_elem_t'($urandom);
			b = gf_pkg::gf_elem_t'($urandom_range(255, 1));
			run_command(gf_pkg::OP_DIV, a, b, int'($urandom_range(3, 0)));
		end
		report_test("divide", DIV_COUNT, errors_before);

		// Zero denominators, then the inverse of every nonzero element
		errors_before = error_count;
		for (int i = 0; i < 8; i++) begin
			a = (i < 2) ? gf_pkg::gf_elem_t'(i) : gf_pkg::gf_elem_t'($urandom);
			run_command(gf_pkg::OP_DIV, a, '0, 0);
			check_value(int'(result), 0, "divide by zero");
		end
		for (int i = 1; i < (1 << `GF_M); i++) begin
			b = gf_pkg::gf_elem_t'(i);
			run_command(gf_pkg::OP_DIV, gf_pkg::gf_elem_t'(1), b, 0);
			check_value(int'(ref_mul(result, b)), 1, "inverse times denominator");
		end
		report_test("divide edge cases", 8 + (1 << `GF_M) - 1, errors_before);

		// A stray start in the middle of a divide has to be dropped
		errors_before = error_count;
		accepts_before = accept_count;
		dones_before = done_count;
		a = gf_pkg::gf_elem_t'($urandom);
		b = gf_pkg::gf_elem_t'($urandom_range(255, 1));
		start = 1'b1;
		op = gf_pkg::OP_DIV;
		operand_a = a;
		operand_b = b;
		step_clock();
		start = 1'b0;
		repeat (3) begin
			step_clock();
		end
		check_value(int'(busy), 1, "busy before the stray start");
		start = 1'b1;
		op = gf_pkg::OP_MUL;
		operand_a = ~a;
		operand_b = ~b;
		step_clock();
		start = 1'b0;
		while (!done) begin
			step_clock();
		end
		check_value(int'(result), int'(ref_div(a, b)), "result after the stray start");
		// Long enough for a second done to show up if the stray start leaked
		repeat (`GF_M + 2) begin
			step_clock();
		end
		check_value(accept_count - accepts_before, 1, "accepted commands");
		check_value(done_count - dones_before, 1, "done pulses");
		report_test("start while busy", 1, errors_before);

		// Mixed commands back to back
		errors_before = error_count;
		accepts_before = accept_count;
		dones_before = done_count;
		for (int i = 0; i < MIXED_COUNT; i++) begin
			run_command(gf_pkg::gf_op_t'($urandom_range(2, 0)), gf_pkg::gf_elem_t'($urandom),
				gf_pkg::gf_elem_t'($urandom), 0);
		end
		@(negedge clk);
		#1;
		check_value(accept_count - accepts_before, MIXED_COUNT, "accepted mixed commands");
		check_value(done_count - dones_before, MIXED_COUNT, "done pulses for mixed commands");
		report_test("back to back", MIXED_COUNT, errors_before);

		check_value(done_count, accept_count, "done pulses against accepted commands");
		$display("Run complete: %0d tests, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== gf_alu.f ====
+incdir+source
+incdir+verification
source/gf_pkg.sv
source/gf_parallel_multiplier.sv
source/gf_cube.sv
source/gf_fermat_divider.sv
source/gf_op_control.sv
source/gf_alu_top.sv
verification/gf_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the GF ALU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module gf_alu_tb \
	-f gf_alu.f \
	-o gf_alu_sim

# A nonzero exit from the simulation, such as a failed assertion, stops here
./obj_dir/gf_alu_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
